//--- Bender.yml
package:
  name: intc_axil

sources:
  - source/intc_pkg.sv
  - source/intc_axil_regs.sv
  - source/intc_channel.sv
  - source/intc_irq_gen.sv
  - source/intc_top.sv
  - target: test
    files:
      - verification/intc_clk_gen.sv
      - verification/intc_tb.sv

//--- source/intc_axil_regs.sv
`timescale 1ns/1ns

module intc_axil_regs (
	input  logic                            S_AXI_ACLK,
	input  logic                            S_AXI_ARESETN,
	// Write address channel
	input  logic [intc_pkg::addr_width-1:0] s_axi_awaddr,
	input  logic                            s_axi_awvalid,
	output logic                            s_axi_awready,
	// Write data channel
	input  logic [intc_pkg::data_width-1:0] s_axi_wdata,
	input  logic                            s_axi_wvalid,
	output logic                            s_axi_wready,
	// Write response channel
	output logic [1:0]                      s_axi_bresp,
	output logic                            s_axi_bvalid,
	input  logic                            s_axi_bready,
	// Read address channel
	input  logic [intc_pkg::addr_width-1:0] s_axi_araddr,
	input  logic                            s_axi_arvalid,
	output logic                            s_axi_arready,
	// Read data channel
	output logic [intc_pkg::data_width-1:0] s_axi_rdata,
	output logic [1:0]                      s_axi_rresp,
	output logic                            s_axi_rvalid,
	input  logic                            s_axi_rready,
	// Control register outputs
	output logic                            gie,
	output logic [intc_pkg::num_intr-1:0]   ier,
	output logic [intc_pkg::num_intr-1:0]   iar,
	// Status from the channels
	input  logic [intc_pkg::num_intr-1:0]   isr,
	input  logic [intc_pkg::num_intr-1:0]   ipr
);

	import intc_pkg::*;

	logic                    wr_accept;
	logic                    wr_en;
	logic [addr_width-3:0]   wr_idx;
	logic                    rd_accept;
	logic                    rd_en;
	logic [addr_width-3:0]   rd_idx;
	logic [data_width-1:0]   rd_mux;

	// ------------------------------------------------------------------------
	// Write channel
	// ------------------------------------------------------------------------

	// Address and data must both be valid
	// Held off while a response is still waiting on B
	assign wr_accept = ~s_axi_awready & s_axi_awvalid & s_axi_wvalid & ~s_axi_bvalid;

	// Handshake cycle, the register is written here
	assign wr_en = s_axi_awready & s_axi_awvalid & s_axi_wready & s_axi_wvalid;

	// Word index straight off the bus, master holds it until ready
	assign wr_idx = s_axi_awaddr[addr_width-1:2];

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_awready <= 1'b0;
			s_axi_wready  <= 1'b0;
		end else begin
			// One-cycle pulse on both readies
			s_axi_awready <= wr_accept;
			s_axi_wready  <= wr_accept;
		end
	end

	// Response valid until the master takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_bvalid <= 1'b0;
		end else if (wr_en) begin
			s_axi_bvalid <= 1'b1;
		end else if (s_axi_bready) begin
			s_axi_bvalid <= 1'b0;
		end
	end

	assign s_axi_bresp = resp_okay;

	// ------------------------------------------------------------------------
	// Control registers
	// ------------------------------------------------------------------------

	// GIE bit 0 and the IER bits
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			gie <= 1'b0;
			ier <= '0;
		end else if (wr_en) begin
			if (wr_idx == reg_gie) begin
				gie <= s_axi_wdata[0];
			end
			if (wr_idx == reg_ier) begin
				ier <= s_axi_wdata[num_intr-1:0];
			end
		end
	end

	// IAR, each written 1 lives for one cycle
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			iar <= '0;
		end else if (wr_en && wr_idx == reg_iar) begin
			iar <= s_axi_wdata[num_intr-1:0];
		end else begin
			iar <= '0;
		end
	end

	// ------------------------------------------------------------------------
	// Read channel
	// ------------------------------------------------------------------------

	// Single outstanding read
	assign rd_accept = ~s_axi_arready & s_axi_arvalid & ~s_axi_rvalid;
	assign rd_en     = s_axi_arready & s_axi_arvalid;

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_arready <= 1'b0;
		end else begin
			s_axi_arready <= rd_accept;
		end
	end

	// Latched word index
	always_ff @(posedge S_AXI_ACLK) begin
		if (rd_accept) begin
			rd_idx <= s_axi_araddr[addr_width-1:2];
		end
	end

	// Register select, unmapped words read as zero
	always_comb begin
		rd_mux = '0;
		case (rd_idx)
			reg_gie: rd_mux[0]            = gie;
			reg_ier: rd_mux[num_intr-1:0] = ier;
			reg_isr: rd_mux[num_intr-1:0] = isr;
			reg_iar: rd_mux[num_intr-1:0] = iar;
			reg_ipr: rd_mux[num_intr-1:0] = ipr;
			default: rd_mux               = '0;
		endcase
	end

	// Data and valid come up together on the edge after the handshake
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			s_axi_rvalid <= 1'b0;
			s_axi_rdata  <= '0;
		end else if (rd_en) begin
			s_axi_rvalid <= 1'b1;
			s_axi_rdata  <= rd_mux;
		end else if (s_axi_rready) begin
			s_axi_rvalid <= 1'b0;
		end
	end

	assign s_axi_rresp = resp_okay;

	// ------------------------------------------------------------------------
	// Protocol checks
	// ------------------------------------------------------------------------

	// A stalled write response must not be withdrawn
	a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid);

	// Same for read data
	a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid);

endmodule

//--- source/intc_channel.sv
`timescale 1ns/1ns

module intc_channel #(
	parameter intc_pkg::detect_mode_e mode = intc_pkg::mode_level_high
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	// Raw external line
	input  logic intr_line,
	// IER bit for this line
	input  logic enable,
	// One-cycle acknowledge from IAR
	input  logic ack,
	output logic status,
	output logic pending
);

	import intc_pkg::*;

	logic hit;
	logic det_q;

	// ------------------------------------------------------------------------
	// Detection, picked by mode
	// ------------------------------------------------------------------------

	if (mode == mode_level_high) begin : gen_level_high
		// Sampled directly, no synchronizer
		assign hit = intr_line;
	end else if (mode == mode_level_low) begin : gen_level_low
		assign hit = ~intr_line;
	end else begin : gen_edge
		// Idle level of the line, falling edge idles high
		localparam logic idle_level = (mode == mode_edge_fall);

		logic sync_q1;
		logic sync_q2;

		// Two-flop synchronizer, ack returns it to idle
		always_ff @(posedge S_AXI_ACLK) begin
			if (!S_AXI_ARESETN || ack) begin
				sync_q1 <= idle_level;
				sync_q2 <= idle_level;
			end else begin
				sync_q1 <= intr_line;
				sync_q2 <= sync_q1;
			end
		end

		// New value in q1 differs from the older one in q2
		assign hit = (mode == mode_edge_rise) ? (sync_q1 & ~sync_q2) : (~sync_q1 & sync_q2);
	end

	// Sticky detect flop
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || ack) begin
			det_q <= 1'b0;
		end else if (hit) begin
			det_q <= 1'b1;
		end
	end

	// ------------------------------------------------------------------------
	// Status and pending
	// ------------------------------------------------------------------------

	// Status trails detect by one edge, pending by one more
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || ack) begin
			status  <= 1'b0;
			pending <= 1'b0;
		end else begin
			status  <= det_q;
			pending <= status & enable;
		end
	end

	// An acknowledged line must not stay pending into the next cycle
	a_ack_clears: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		ack |=> !pending);

endmodule

//--- source/intc_irq_gen.sv
`timescale 1ns/1ns

module intc_irq_gen (
	input  logic                          S_AXI_ACLK,
	input  logic                          S_AXI_ARESETN,
	// Global enable
	input  logic                          gie,
	// Pending bits from all channels
	input  logic [intc_pkg::num_intr-1:0] ipr,
	// Acknowledge pulses from IAR
	input  logic [intc_pkg::num_intr-1:0] iar,
	// Level-high interrupt request
	output logic                          irq
);

	logic ack_any_q;

	// ------------------------------------------------------------------------
	// Acknowledge capture
	// ------------------------------------------------------------------------

	// Any line acknowledged, one cycle late
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			ack_any_q <= 1'b0;
		end else begin
			ack_any_q <= |iar;
		end
	end

	// ------------------------------------------------------------------------
	// Request output
	// ------------------------------------------------------------------------

	// Clear wins over set
	// Set needs a pending line and the global enable
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN || ack_any_q) begin
			irq <= 1'b0;
		end else if (gie && |ipr) begin
			irq <= 1'b1;
		end
	end

	// GIE low blocks every new request
	a_irq_needs_gie: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		$rose(irq) |-> $past(gie));

endmodule

//--- source/intc_pkg.sv
package intc_pkg;

	// ------------------------------------------------------------------------
	// Sizes
	// ------------------------------------------------------------------------

	// Number of external interrupt lines
	localparam int num_intr = 4;

	// AXI4-Lite data bus width
	localparam int data_width = 32;

	// AXI4-Lite address width, word index sits in bits 4:2
	localparam int addr_width = 5;

	// OKAY response, the only one this slave returns
	localparam logic [1:0] resp_okay = 2'b00;

	// ------------------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------------------

	// Word index of each register
	// Indices 5 to 7 are unmapped
	typedef enum logic [addr_width-3:0] {
		reg_gie = 3'd0,
		reg_ier = 3'd1,
		reg_isr = 3'd2,
		reg_iar = 3'd3,
		reg_ipr = 3'd4
	} reg_addr_e;

	// ------------------------------------------------------------------------
	// Line detection
	// ------------------------------------------------------------------------

	// How a line is turned into a detect event
	typedef enum logic [1:0] {
		mode_level_high,
		mode_level_low,
		mode_edge_rise,
		mode_edge_fall
	} detect_mode_e;

	// Per-line mode, fixed at build time
	// Entry 0 belongs to line 0
	localparam detect_mode_e line_modes [num_intr] = '{
		mode_level_high,
		mode_level_low,
		mode_edge_rise,
		mode_edge_fall
	};

endpackage

//--- source/intc_top.sv
`timescale 1ns/1ns

module intc_top (
	input  logic                            S_AXI_ACLK,
	input  logic                            S_AXI_ARESETN,
	// AXI4-Lite write side
	input  logic [intc_pkg::addr_width-1:0] s_axi_awaddr,
	input  logic                            s_axi_awvalid,
	output logic                            s_axi_awready,
	input  logic [intc_pkg::data_width-1:0] s_axi_wdata,
	input  logic                            s_axi_wvalid,
	output logic                            s_axi_wready,
	output logic [1:0]                      s_axi_bresp,
	output logic                            s_axi_bvalid,
	input  logic                            s_axi_bready,
	// AXI4-Lite read side
	input  logic [intc_pkg::addr_width-1:0] s_axi_araddr,
	input  logic                            s_axi_arvalid,
	output logic                            s_axi_arready,
	output logic [intc_pkg::data_width-1:0] s_axi_rdata,
	output logic [1:0]                      s_axi_rresp,
	output logic                            s_axi_rvalid,
	input  logic                            s_axi_rready,
	// Interrupt lines and their acknowledges
	input  logic [intc_pkg::num_intr-1:0]   intr_input,
	output logic [intc_pkg::num_intr-1:0]   intr_ack,
	output logic                            irq
);

	import intc_pkg::*;

	logic                gie;
	logic [num_intr-1:0] ier;
	logic [num_intr-1:0] isr;
	logic [num_intr-1:0] ipr;

	// Register front end, IAR drives intr_ack directly
	intc_axil_regs u_regs (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.gie           (gie),
		.ier           (ier),
		.iar           (intr_ack),
		.isr           (isr),
		.ipr           (ipr)
	);

	// One channel per line, mode from the package table
	for (genvar i = 0; i < num_intr; i++) begin : gen_chan
		intc_channel #(
			.mode (line_modes[i])
		) u_chan (
			.S_AXI_ACLK    (S_AXI_ACLK),
			.S_AXI_ARESETN (S_AXI_ARESETN),
			.intr_line     (intr_input[i]),
			.enable        (ier[i]),
			.ack           (intr_ack[i]),
			.status        (isr[i]),
			.pending       (ipr[i])
		);
	end

	// Collector for the request output
	intc_irq_gen u_irq (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.gie           (gie),
		.ipr           (ipr),
		.iar           (intr_ack),
		.irq           (irq)
	);

endmodule

//--- sources.f
source/intc_pkg.sv
source/intc_axil_regs.sv
source/intc_channel.sv
source/intc_irq_gen.sv
source/intc_top.sv
verification/intc_clk_gen.sv
verification/intc_tb.sv

//--- verification/intc_clk_gen.sv
`timescale 1ns/1ns

module intc_clk_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 5
) (
	output logic S_AXI_ACLK,
	output logic S_AXI_ARESETN
);

	// Free-running clock, starts low
	initial begin
		S_AXI_ACLK = 1'b0;
		forever #(period_ns / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// Reset held low for a fixed number of cycles
	// Released on a rising edge, as the DUT resets synchronously
	initial begin
		S_AXI_ARESETN = 1'b0;
		repeat (reset_cycles) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
	end

endmodule

//--- verification/intc_tb.sv
`timescale 1ns/1ns

module intc_tb;

	import intc_pkg::*;

	// Upper bound for every polling loop
	localparam int poll_limit = 200;
	localparam int n_rows     = 8;

	// Idle level per line
	// Line 1 is active low and line 3 falls
	localparam logic [num_intr-1:0] idle_lines = 4'b1010;

	logic                  S_AXI_ACLK;
	logic                  S_AXI_ARESETN;
	logic [addr_width-1:0] s_axi_awaddr;
	logic                  s_axi_awvalid;
	logic                  s_axi_awready;
	logic [data_width-1:0] s_axi_wdata;
	logic                  s_axi_wvalid;
	logic                  s_axi_wready;
	logic [1:0]            s_axi_bresp;
	logic                  s_axi_bvalid;
	logic                  s_axi_bready;
	logic [addr_width-1:0] s_axi_araddr;
	logic                  s_axi_arvalid;
	logic                  s_axi_arready;
	logic [data_width-1:0] s_axi_rdata;
	logic [1:0]            s_axi_rresp;
	logic                  s_axi_rvalid;
	logic                  s_axi_rready;
	logic [num_intr-1:0]   intr_input;
	logic [num_intr-1:0]   intr_ack;
	logic                  irq;

	// intr_ack seen on the first and second negedge after a write handshake
	logic [num_intr-1:0]   ack_seen_first;
	logic [num_intr-1:0]   ack_seen_next;

	// One table row of stimulus and expected values
	typedef struct packed {
		logic [1:0]          line;
		logic [num_intr-1:0] ier;
		logic                gie;
		logic [num_intr-1:0] isr;
		logic [num_intr-1:0] ipr;
		logic                irq;
	} row_t;

	row_t rows [n_rows];

	intc_clk_gen clk0 (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN)
	);

	intc_top dut0 (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.intr_input    (intr_input),
		.intr_ack      (intr_ack),
		.irq           (irq)
	);

	// ------------------------------------------------------------------------
	// Reporting
	// ------------------------------------------------------------------------

	task automatic fail_run();
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		fail_run();
	endtask

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
			fail_run();
		end
	endtask

	// ------------------------------------------------------------------------
	// AXI4-Lite master
	// ------------------------------------------------------------------------

	// Stall is the number of cycles BREADY stays low once BVALID is up
	task automatic write_reg(input int idx, input logic [31:0] data, input int stall);
		int cnt;
		int i;
		@(posedge S_AXI_ACLK);
		s_axi_awaddr  <= addr_width'(idx * 4);
		s_axi_awvalid <= 1'b1;
		s_axi_wdata   <= data;
		s_axi_wvalid  <= 1'b1;
		s_axi_bready  <= (stall == 0);
		cnt = 0;
		do begin
			@(negedge S_AXI_ACLK);
			cnt++;
			if (cnt > poll_limit) report_timeout("AWREADY and WREADY");
		end while (!(s_axi_awready && s_axi_wready));
		// Handshake edge
		@(posedge S_AXI_ACLK);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid  <= 1'b0;
		@(negedge S_AXI_ACLK);
		ack_seen_first = intr_ack;
		// Both readies last a single cycle
		check_value("s_axi_awready", 0, s_axi_awready);
		check_value("s_axi_wready", 0, s_axi_wready);
		check_value("s_axi_bvalid", 1, s_axi_bvalid);
		check_value("s_axi_bresp", resp_okay, s_axi_bresp);
		@(negedge S_AXI_ACLK);
		ack_seen_next = intr_ack;
		if (stall > 0) begin
			check_value("s_axi_bvalid", 1, s_axi_bvalid);
			for (i = 1; i < stall; i++) begin
				@(negedge S_AXI_ACLK);
				check_value("s_axi_bvalid", 1, s_axi_bvalid);
				check_value("s_axi_bresp", resp_okay, s_axi_bresp);
			end
			@(posedge S_AXI_ACLK);
			s_axi_bready <= 1'b1;
		end
	endtask

	// Stall is the number of cycles RREADY stays low once RVALID is up
	task automatic read_reg(input int idx, input int stall, output logic [31:0] data);
		int cnt;
		int i;
		@(posedge S_AXI_ACLK);
		s_axi_araddr  <= addr_width'(idx * 4);
		s_axi_arvalid <= 1'b1;
		s_axi_rready  <= (stall == 0);
		cnt = 0;
		do begin
			@(negedge S_AXI_ACLK);
			cnt++;
			if (cnt > poll_limit) report_timeout("ARREADY");
		end while (!s_axi_arready);
		@(posedge S_AXI_ACLK);
		s_axi_arvalid <= 1'b0;
		// Data comes up on the edge after the address handshake
		@(negedge S_AXI_ACLK);
		check_value("s_axi_arready", 0, s_axi_arready);
		check_value("s_axi_rvalid", 1, s_axi_rvalid);
		check_value("s_axi_rresp", resp_okay, s_axi_rresp);
		data = s_axi_rdata;
		for (i = 0; i < stall; i++) begin
			@(negedge S_AXI_ACLK);
			check_value("s_axi_rvalid", 1, s_axi_rvalid);
			check_value("s_axi_rdata", data, s_axi_rdata);
		end
		if (stall > 0) begin
			@(posedge S_AXI_ACLK);
			s_axi_rready <= 1'b1;
		end
	endtask

	// ------------------------------------------------------------------------
	// Line stimulus and table
	// ------------------------------------------------------------------------

	task automatic set_line(input int line, input logic active);
		@(posedge S_AXI_ACLK);
		intr_input[line] <= active ? ~idle_lines[line] : idle_lines[line];
	endtask

	// Two cycles away from idle and then back
	task automatic pulse_line(input int line);
		set_line(line, 1'b1);
		@(posedge S_AXI_ACLK);
		set_line(line, 1'b0);
	endtask

	task automatic wait_irq(input logic level);
		int cnt;
		cnt = 0;
		do begin
			@(negedge S_AXI_ACLK);
			cnt++;
			if (cnt > poll_limit) report_timeout(level ? "irq to rise" : "irq to fall");
		end while (irq !== level);
	endtask

	// Columns are line, IER, GIE, ISR, IPR and irq
	task automatic fill_table();
		rows[0] = {2'd0, 4'hF, 1'b1, 4'h1, 4'h1, 1'b1};
		rows[1] = {2'd0, 4'h0, 1'b1, 4'h1, 4'h0, 1'b0};
		rows[2] = {2'd1, 4'h2, 1'b0, 4'h2, 4'h2, 1'b0};
		rows[3] = {2'd1, 4'h3, 1'b1, 4'h2, 4'h2, 1'b1};
		rows[4] = {2'd2, 4'h4, 1'b1, 4'h4, 4'h4, 1'b1};
		rows[5] = {2'd3, 4'h8, 1'b0, 4'h8, 4'h8, 1'b0};
		rows[6] = {2'd3, 4'h7, 1'b1, 4'h8, 4'h0, 1'b0};
		rows[7] = {2'd2, 4'hC, 1'b1, 4'h4, 4'h4, 1'b1};
	endtask

	task automatic run_row(input int r);
		int          line;
		int          cnt;
		int          i;
		logic        edge_line;
		logic [31:0] isr_val;
		logic [31:0] rd;
		line      = rows[r].line;
		edge_line = (line_modes[line] == mode_edge_rise) || (line_modes[line] == mode_edge_fall);
		write_reg(reg_ier, rows[r].ier, 0);
		write_reg(reg_gie, rows[r].gie, 0);
		// Edge lines are back at idle before ISR is polled
		if (edge_line) begin
			pulse_line(line);
		end else begin
			set_line(line, 1'b1);
		end
		cnt = 0;
		do begin
			read_reg(reg_isr, 0, isr_val);
			cnt++;
			if (cnt > poll_limit) report_timeout("the ISR bit");
		end while (isr_val[line] !== 1'b1);
		check_value("isr", rows[r].isr, isr_val);
		read_reg(reg_ipr, 0, rd);
		check_value("ipr", rows[r].ipr, rd);
		// irq only with a pending line and GIE set
		if (rows[r].irq) begin
			wait_irq(1'b1);
		end else begin
			for (i = 0; i < 10; i++) begin
				@(negedge S_AXI_ACLK);
				check_value("irq", 0, irq);
			end
		end
		if (!edge_line) set_line(line, 1'b0);
		// Acknowledge pulse shows one edge after the handshake
		write_reg(reg_iar, 1 << line, 0);
		check_value("intr_ack", 1 << line, ack_seen_first);
		check_value("intr_ack", 0, ack_seen_next);
		wait_irq(1'b0);
		read_reg(reg_isr, 0, rd);
		check_value("isr", 0, rd);
		read_reg(reg_ipr, 0, rd);
		check_value("ipr", 0, rd);
		read_reg(reg_iar, 0, rd);
		check_value("iar", 0, rd);
		check_value("irq", 0, irq);
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial begin
		int          idx;
		int          cnt;
		int          stall;
		logic [31:0] rd;
		logic [31:0] pat;
		logic [31:0] gie_pat;
		void'($urandom(71));
		s_axi_awaddr  <= '0;
		s_axi_awvalid <= 1'b0;
		s_axi_wdata   <= '0;
		s_axi_wvalid  <= 1'b0;
		s_axi_bready  <= 1'b0;
		s_axi_araddr  <= '0;
		s_axi_arvalid <= 1'b0;
		s_axi_rready  <= 1'b0;
		intr_input    <= idle_lines;
		fill_table();

		cnt = 0;
		do begin
			@(negedge S_AXI_ACLK);
			cnt++;
			if (cnt > poll_limit) report_timeout("reset release");
		end while (!S_AXI_ARESETN);

		// Reset state of the five registers and of unmapped index 5
		check_value("irq", 0, irq);
		check_value("intr_ack", 0, intr_ack);
		for (idx = 0; idx < 6; idx++) begin
			read_reg(idx, 0, rd);
			check_value("s_axi_rdata", 0, rd);
		end

		// GIE keeps bit 0 and IER keeps the low line bits
		gie_pat = $urandom;
		write_reg(reg_gie, gie_pat, 0);
		read_reg(reg_gie, 0, rd);
		check_value("gie", gie_pat & 32'h1, rd);
		pat = $urandom;
		write_reg(reg_ier, pat, 0);
		read_reg(reg_ier, 0, rd);
		check_value("ier", pat & ((1 << num_intr) - 1), rd);

		// Read-only and unmapped words ignore writes and keep reading zero
		// IAR is left out as it clears itself
		for (idx = 2; idx < 8; idx++) begin
			if (idx != reg_iar) begin
				write_reg(idx, $urandom, 0);
				read_reg(idx, 0, rd);
				check_value("s_axi_rdata", 0, rd);
			end
		end
		// GIE and IER untouched by those writes
		read_reg(reg_gie, 0, rd);
		check_value("gie", gie_pat & 32'h1, rd);
		read_reg(reg_ier, 0, rd);
		check_value("ier", pat & ((1 << num_intr) - 1), rd);
		write_reg(reg_gie, 0, 0);
		write_reg(reg_ier, 0, 0);

		// Lines held at idle raise nothing
		repeat (20) @(negedge S_AXI_ACLK);
		read_reg(reg_isr, 0, rd);
		check_value("isr", 0, rd);

		for (idx = 0; idx < n_rows; idx++) begin
			run_row(idx);
		end

		// Back-pressure on B and R
		repeat (4) begin
			pat   = $urandom;
			stall = ($urandom % 8) + 1;
			write_reg(reg_ier, pat, stall);
			stall = ($urandom % 8) + 1;
			read_reg(reg_ier, stall, rd);
			check_value("ier", pat & ((1 << num_intr) - 1), rd);
		end

		$display("RESULT: PASS");
		$finish;
	end

endmodule
